// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the rv_pipe testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rv_pipe -f rv_pipe.f \
    && output="$(./obj_dir/Vtb_rv_pipe)" \
    && echo "$output" \
    && grep -q "Simulation completed successfully" <<< "$output" \
    && echo "run_sim: PASS" \
    || { echo "run_sim: FAIL"; exit 1; }

// ==== rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_defines.svh"

module rv_decode (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire rv_pipe_pkg::word_t     imem_data_i,
    input  wire rv_pipe_pkg::redirect_t redirect_i,
    input  wire rv_pipe_pkg::wb_t       wb_i,
    output rv_pipe_pkg::word_t          imem_addr_o,
    output rv_pipe_pkg::id_ex_t         id_ex_o
);
    import rv_pipe_pkg::*;

    word_t     pc_q;
    logic      ifid_vld_q;
    word_t     ifid_pc_q;
    word_t     ifid_insn_q;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_u;
    word_t     imm_j;
    word_t     imm;
    ctrl_t     ctrl;
    logic      load_use;
    logic      stall;
    id_ex_t    id_ex_q;
    word_t     regs_q [2**`RV_REG_AW];

    // Bit 30 selects SUB only for register-register ops, SRA/SRAI for both
    function automatic alu_op_e alu_decode(
        input funct3_t funct3,
        input logic    alt,
        input logic    is_op
    );
        alu_op_e op;
        case (funct3)
            3'b000:  op = (is_op && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // x0 is hardwired, a write in the same cycle is bypassed
    function automatic word_t rf_read(input reg_addr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (wb_i.we && (wb_i.rd == addr)) begin
            val = wb_i.data;
        end else begin
            val = regs_q[addr];
        end
        return val;
    endfunction

    // Fetch
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= `RV_RESET_PC;
        end else if (redirect_i.taken) begin
            pc_q <= redirect_i.target;
        end else if (!stall) begin
            pc_q <= pc_q + word_t'(4);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ifid_vld_q <= 1'b0;
        end else if (redirect_i.taken) begin
            ifid_vld_q <= 1'b0;
        end else if (!stall) begin
            ifid_vld_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall) begin
            ifid_pc_q   <= pc_q;
            ifid_insn_q <= imem_data_i;
        end
    end

    assign rs1 = ifid_insn_q[19:15];
    assign rs2 = ifid_insn_q[24:20];

    always_ff @(posedge clk_i) begin
        if (wb_i.we && (wb_i.rd != '0)) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    always_comb begin
        rs1_val = rf_read(rs1);
        rs2_val = rf_read(rs2);
    end

    assign imm_i = {{20{ifid_insn_q[31]}}, ifid_insn_q[31:20]};
    assign imm_s = {{20{ifid_insn_q[31]}}, ifid_insn_q[31:25], ifid_insn_q[11:7]};
    assign imm_b = {{19{ifid_insn_q[31]}}, ifid_insn_q[31], ifid_insn_q[7],
                    ifid_insn_q[30:25], ifid_insn_q[11:8], 1'b0};
    assign imm_u = {ifid_insn_q[31:12], 12'b0};
    assign imm_j = {{11{ifid_insn_q[31]}}, ifid_insn_q[31], ifid_insn_q[19:12],
                    ifid_insn_q[20], ifid_insn_q[30:21], 1'b0};

    // Control decode and immediate select
    always_comb begin
        ctrl = '0;
        imm  = '0;
        if (ifid_vld_q) begin
            ctrl.valid = 1'b1;
            case (opcode_e'(ifid_insn_q[6:0]))
                OPC_OP: begin
                    ctrl.rd_we  = 1'b1;
                    ctrl.alu_op = alu_decode(ifid_insn_q[14:12], ifid_insn_q[30], 1'b1);
                end
                OPC_OP_IMM: begin
                    ctrl.rd_we    = 1'b1;
                    ctrl.op_b_imm = 1'b1;
                    ctrl.alu_op   = alu_decode(ifid_insn_q[14:12], ifid_insn_q[30], 1'b0);
                    imm           = imm_i;
                end
                OPC_LUI: begin
                    ctrl.rd_we    = 1'b1;
                    ctrl.op_b_imm = 1'b1;
                    ctrl.alu_op   = ALU_PASS_B;
                    imm           = imm_u;
                end
                OPC_AUIPC: begin
                    ctrl.rd_we    = 1'b1;
                    ctrl.op_a_pc  = 1'b1;
                    ctrl.op_b_imm = 1'b1;
                    imm           = imm_u;
                end
                OPC_LOAD: begin
                    ctrl.rd_we    = 1'b1;
                    ctrl.is_load  = 1'b1;
                    ctrl.op_b_imm = 1'b1;
                    imm           = imm_i;
                end
                OPC_STORE: begin
                    ctrl.is_store = 1'b1;
                    ctrl.op_b_imm = 1'b1;
                    imm           = imm_s;
                end
                OPC_BRANCH: begin
                    ctrl.is_branch = 1'b1;
                    imm            = imm_b;
                end
                OPC_JAL: begin
                    ctrl.rd_we  = 1'b1;
                    ctrl.is_jal = 1'b1;
                    imm         = imm_j;
                end
                default: ;
            endcase
        end
    end

    // Load in EX whose rd feeds the instruction in ID
    assign load_use = id_ex_q.ctrl.is_load && (id_ex_q.rd != '0) && ifid_vld_q &&
                      ((id_ex_q.rd == rs1) || (id_ex_q.rd == rs2));
    assign stall    = load_use && !redirect_i.taken;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            id_ex_q <= '0;
        end else if (redirect_i.taken || stall) begin
            id_ex_q.ctrl <= '0;
        end else begin
            id_ex_q.ctrl    <= ctrl;
            id_ex_q.pc      <= ifid_pc_q;
            id_ex_q.rs1_val <= rs1_val;
            id_ex_q.rs2_val <= rs2_val;
            id_ex_q.rs1     <= rs1;
            id_ex_q.rs2     <= rs2;
            id_ex_q.rd      <= ifid_insn_q[11:7];
            id_ex_q.imm     <= imm;
            id_ex_q.funct3  <= ifid_insn_q[14:12];
        end
    end

    assign imem_addr_o = pc_q;
    assign id_ex_o     = id_ex_q;

endmodule

`default_nettype wire

// ==== rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  wire logic                clk_i,
    input  wire logic                rst_ni,
    input  wire rv_pipe_pkg::id_ex_t id_ex_i,
    input  wire rv_pipe_pkg::wb_t    wb_i,
    output rv_pipe_pkg::redirect_t   redirect_o,
    output rv_pipe_pkg::ex_mem_t     ex_mem_o
);
    import rv_pipe_pkg::*;

    ex_mem_t    ex_mem_q;
    word_t      rs1_fwd;
    word_t      rs2_fwd;
    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    word_t      alu_res;
    word_t      link;
    word_t      target;
    logic       br_take;

    // Younger producer wins, a load in EX/MEM has no data yet
    function automatic word_t fwd(input reg_addr_t rs, input word_t id_val);
        word_t val;
        if (ex_mem_q.rd_we && !ex_mem_q.is_load && (ex_mem_q.rd != '0) &&
            (ex_mem_q.rd == rs)) begin
            val = ex_mem_q.alu_res;
        end else if (wb_i.we && (wb_i.rd == rs)) begin
            val = wb_i.data;
        end else begin
            val = id_val;
        end
        return val;
    endfunction

    always_comb begin
        rs1_fwd = fwd(id_ex_i.rs1, id_ex_i.rs1_val);
        rs2_fwd = fwd(id_ex_i.rs2, id_ex_i.rs2_val);
    end

    assign op_a  = id_ex_i.ctrl.op_a_pc ? id_ex_i.pc : rs1_fwd;
    assign op_b  = id_ex_i.ctrl.op_b_imm ? id_ex_i.imm : rs2_fwd;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_res = word_t'(op_a < op_b);
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // Branch conditions on forwarded register values
    always_comb begin
        case (id_ex_i.funct3)
            3'b000:  br_take = (rs1_fwd == rs2_fwd);
            3'b001:  br_take = (rs1_fwd != rs2_fwd);
            3'b100:  br_take = ($signed(rs1_fwd) < $signed(rs2_fwd));
            3'b101:  br_take = ($signed(rs1_fwd) >= $signed(rs2_fwd));
            3'b110:  br_take = (rs1_fwd < rs2_fwd);
            3'b111:  br_take = (rs1_fwd >= rs2_fwd);
            default: br_take = 1'b0;
        endcase
    end

    assign link   = id_ex_i.pc + word_t'(4);
    assign target = id_ex_i.pc + id_ex_i.imm;

    // Not-taken is the prediction, so only a taken branch or JAL redirects
    assign redirect_o = '{
        taken:  id_ex_i.ctrl.is_jal || (id_ex_i.ctrl.is_branch && br_take),
        target: target
    };

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.valid    <= id_ex_i.ctrl.valid;
            ex_mem_q.rd_we    <= id_ex_i.ctrl.rd_we;
            ex_mem_q.is_load  <= id_ex_i.ctrl.is_load;
            ex_mem_q.is_store <= id_ex_i.ctrl.is_store;
            ex_mem_q.funct3   <= id_ex_i.funct3;
            ex_mem_q.rd       <= id_ex_i.rd;
            ex_mem_q.alu_res  <= id_ex_i.ctrl.is_jal ? link : alu_res;
            ex_mem_q.st_data  <= rs2_fwd;
            ex_mem_q.pc       <= id_ex_i.pc;
        end
    end

    assign ex_mem_o = ex_mem_q;

endmodule

`default_nettype wire

// ==== rv_pipe.f ====
+incdir+.
rv_pipe_pkg.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_pipe.sv
tb_rv_pipe.sv

// ==== rv_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_pipe (
    input  wire logic               clk_i,
    input  wire logic               rst_ni,
    input  wire rv_pipe_pkg::word_t imem_data_i,
    output rv_pipe_pkg::word_t      imem_addr_o,
    output logic                    insn_vld_o,
    output rv_pipe_pkg::word_t      pc_debug_o,
    output rv_pipe_pkg::retire_t    retire_o
);
    import rv_pipe_pkg::*;

    id_ex_t    id_ex;
    redirect_t redirect;
    ex_mem_t   ex_mem;
    wb_t       wb;

    // Fetch, register read and ID/EX
    rv_decode u_decode (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .imem_data_i (imem_data_i),
        .redirect_i  (redirect),
        .wb_i        (wb),
        .imem_addr_o (imem_addr_o),
        .id_ex_o     (id_ex)
    );

    rv_execute u_execute (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .id_ex_i    (id_ex),
        .wb_i       (wb),
        .redirect_o (redirect),
        .ex_mem_o   (ex_mem)
    );

    // Data memory and writeback
    rv_result u_result (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .ex_mem_i (ex_mem),
        .wb_o     (wb),
        .retire_o (retire_o)
    );

    assign insn_vld_o = retire_o.valid;
    assign pc_debug_o = retire_o.pc;

endmodule

`default_nettype wire

// ==== rv_pipe_defines.svh ====
`ifndef RV_PIPE_DEFINES_SVH
`define RV_PIPE_DEFINES_SVH

// Datapath width of the integer core
`define RV_XLEN 32

// Register index width, 32 architectural registers
`define RV_REG_AW 5

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Private data memory, in 32-bit words
`define RV_DMEM_WORDS 64

// Word index width, must match RV_DMEM_WORDS
`define RV_DMEM_AW 6

`endif

// ==== rv_pipe_pkg.sv ====
`default_nettype none

`include "rv_pipe_defines.svh"

package rv_pipe_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;
    typedef logic [2:0]            funct3_t;

    // Major opcodes kept by this core, anything else decodes as a no-op
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // Decoded control, all zero for a bubble
    typedef struct packed {
        logic    valid;
        logic    rd_we;
        logic    is_load;
        logic    is_store;
        logic    is_branch;
        logic    is_jal;
        logic    op_a_pc;
        logic    op_b_imm;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     rs1_val;
        word_t     rs2_val;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        funct3_t   funct3;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      rd_we;
        logic      is_load;
        logic      is_store;
        funct3_t   funct3;
        reg_addr_t rd;
        word_t     alu_res;
        word_t     st_data;
        word_t     pc;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      rd_we;
        reg_addr_t rd;
        word_t     rd_data;
    } retire_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

// ==== rv_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_defines.svh"

module rv_result (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire rv_pipe_pkg::ex_mem_t ex_mem_i,
    output rv_pipe_pkg::wb_t          wb_o,
    output rv_pipe_pkg::retire_t      retire_o
);
    import rv_pipe_pkg::*;

    word_t                  dmem_q [`RV_DMEM_WORDS];
    logic [`RV_DMEM_AW-1:0] word_idx;
    logic [1:0]             byte_off;
    logic [3:0]             byte_en;
    word_t                  wr_data;
    word_t                  rd_word;
    logic [7:0]             rd_byte;
    logic [15:0]            rd_half;
    word_t                  ld_data;
    retire_t                mem_wb_q;

    // Upper address bits wrap around the memory depth
    assign word_idx = ex_mem_i.alu_res[`RV_DMEM_AW+1:2];
    assign byte_off = ex_mem_i.alu_res[1:0];

    // Replicate store data so every lane sees its bytes
    always_comb begin
        case (ex_mem_i.funct3[1:0])
            2'b00: begin
                byte_en = 4'b0001 << byte_off;
                wr_data = {4{ex_mem_i.st_data[7:0]}};
            end
            2'b01: begin
                byte_en = byte_off[1] ? 4'b1100 : 4'b0011;
                wr_data = {2{ex_mem_i.st_data[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wr_data = ex_mem_i.st_data;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (ex_mem_i.is_store) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    dmem_q[word_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    assign rd_word = dmem_q[word_idx];
    assign rd_byte = rd_word[8*byte_off +: 8];
    assign rd_half = byte_off[1] ? rd_word[31:16] : rd_word[15:0];

    // LB, LH, LBU, LHU, anything else reads the full word
    always_comb begin
        case (ex_mem_i.funct3)
            3'b000:  ld_data = {{24{rd_byte[7]}}, rd_byte};
            3'b001:  ld_data = {{16{rd_half[15]}}, rd_half};
            3'b100:  ld_data = {24'b0, rd_byte};
            3'b101:  ld_data = {16'b0, rd_half};
            default: ld_data = rd_word;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.valid   <= ex_mem_i.valid;
            mem_wb_q.pc      <= ex_mem_i.pc;
            mem_wb_q.rd_we   <= ex_mem_i.rd_we && (ex_mem_i.rd != '0);
            mem_wb_q.rd      <= ex_mem_i.rd;
            mem_wb_q.rd_data <= ex_mem_i.is_load ? ld_data : ex_mem_i.alu_res;
        end
    end

    assign wb_o = '{
        we:   mem_wb_q.rd_we,
        rd:   mem_wb_q.rd,
        data: mem_wb_q.rd_data
    };
    assign retire_o = mem_wb_q;

endmodule

`default_nettype wire

// ==== rv_iss_model.svh ====
`ifndef RV_ISS_MODEL_SVH
`define RV_ISS_MODEL_SVH

// Behavior classes used to group the retire checks
localparam int K_RESET   = 0;
localparam int K_ARITH   = 1;
localparam int K_DEP     = 2;
localparam int K_LOADUSE = 3;
localparam int K_CTRL    = 4;
localparam int K_MEM     = 5;

// Prologue writes x1..x7 and 16 data words, then runs a load-use chain
localparam int PRO_LEN = 26;

// One expected retirement in program order
typedef struct packed {
    word_t      pc;
    logic       rd_we;
    reg_addr_t  rd;
    word_t      data;
    logic [2:0] kind;
} exp_t;

word_t      prog [PROG_LEN];
exp_t       exp_q [$];
word_t      mreg [32];
logic [7:0] mbyte [4*`RV_DMEM_WORDS];

function automatic word_t rand_insn(input int idx);
    logic [3:0]  pick;
    logic [2:0]  f3;
    logic        alt;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [5:0]  ofs;
    logic [12:0] bimm;
    logic [20:0] jimm;
    int          off;
    word_t       insn;
    pick  = 4'(rand_bits(4));
    f3    = 3'(rand_bits(3));
    alt   = 1'(rand_bits(1));
    rd    = reg_addr_t'(rand_bits(3));
    rs1   = reg_addr_t'(rand_bits(3));
    rs2   = reg_addr_t'(rand_bits(3));
    imm12 = 12'(rand_bits(12));
    imm20 = 20'(rand_bits(20));
    ofs   = 6'(rand_bits(6));
    off   = 1 + int'(rand_bits(4));
    // Forward jumps never pass the final self-loop
    if (idx + off > PROG_LEN - 1) begin
        off = PROG_LEN - 1 - idx;
    end
    bimm = 13'(4 * off);
    jimm = 21'(4 * off);
    case (pick)
        4'd0, 4'd1, 4'd2, 4'd3: begin
            alt  = alt && ((f3 == 3'b000) || (f3 == 3'b101));
            insn = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
        end
        4'd4, 4'd5, 4'd6: begin
            // Shifts keep the upper immediate bits legal
            if (f3 == 3'b001) begin
                imm12 = {7'b0, imm12[4:0]};
            end else if (f3 == 3'b101) begin
                imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
            end
            insn = {imm12, rs1, f3, rd, 7'b0010011};
        end
        4'd7:  insn = {imm20, rd, 7'b0110111};
        4'd8:  insn = {imm20, rd, 7'b0010111};
        4'd9, 4'd10: begin
            // LB, LH, LW, LW, LBU, LHU, LBU, LHU
            if (f3[2]) begin
                f3[1] = 1'b0;
            end else if (f3[1:0] == 2'b11) begin
                f3 = 3'b010;
            end
            if (f3[1:0] == 2'b01) begin
                ofs[0] = 1'b0;
            end else if (f3[1:0] == 2'b10) begin
                ofs[1:0] = 2'b00;
            end
            insn = {6'b0, ofs, 5'd0, f3, rd, 7'b0000011};
        end
        4'd11, 4'd12: begin
            f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
            if (f3[1:0] == 2'b01) begin
                ofs[0] = 1'b0;
            end else if (f3[1:0] == 2'b10) begin
                ofs[1:0] = 2'b00;
            end
            insn = {6'b0, ofs[5], rs2, 5'd0, f3, ofs[4:0], 7'b0100011};
        end
        4'd13, 4'd14: begin
            // Map the two reserved encodings onto BEQ and BNE
            if (f3[2:1] == 2'b01) begin
                f3 = {2'b00, f3[0]};
            end
            insn = {bimm[12], bimm[10:5], rs2, rs1, f3, bimm[4:1], bimm[11], 7'b1100011};
        end
        default: begin
            insn = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], rd, 7'b1101111};
        end
    endcase
    return insn;
endfunction

task automatic gen_program();
    int          i;
    logic [11:0] ofs;
    for (i = 1; i < 8; i++) begin
        prog[i-1] = {12'(rand_bits(12)), 5'd0, 3'b000, 5'(i), 7'b0010011};
    end
    // Every byte a later load can reach gets written first
    for (i = 0; i < 16; i++) begin
        ofs         = 12'(4 * i);
        prog[7 + i] = {ofs[11:5], 5'(i % 7 + 1), 5'd0, 3'b010, ofs[4:0], 7'b0100011};
    end
    // lw x1, 4(x0) then add x2, x1, x1 then add x3, x2, x1
    prog[23] = {12'd4, 5'd0, 3'b010, 5'd1, 7'b0000011};
    prog[24] = {7'b0, 5'd1, 5'd1, 3'b000, 5'd2, 7'b0110011};
    prog[25] = {7'b0, 5'd1, 5'd2, 3'b000, 5'd3, 7'b0110011};
    for (i = PRO_LEN; i < PROG_LEN - 1; i++) begin
        prog[i] = rand_insn(i);
    end
    // jal x0, 0
    prog[PROG_LEN-1] = 32'h0000_006f;
endtask

function automatic word_t alu_model(
    input logic [2:0] f3,
    input logic       alt,
    input word_t      a,
    input word_t      b
);
    word_t r;
    case (f3)
        3'b000:  r = alt ? a - b : a + b;
        3'b001:  r = a << b[4:0];
        3'b010:  r = word_t'($signed(a) < $signed(b));
        3'b011:  r = word_t'(a < b);
        3'b100:  r = a ^ b;
        3'b101: begin
            if (alt) begin
                r = $signed(a) >>> b[4:0];
            end else begin
                r = a >> b[4:0];
            end
        end
        3'b110:  r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    logic t;
    case (f3)
        3'b000:  t = (a == b);
        3'b001:  t = (a != b);
        3'b100:  t = ($signed(a) < $signed(b));
        3'b101:  t = ($signed(a) >= $signed(b));
        3'b110:  t = (a < b);
        default: t = (a >= b);
    endcase
    return t;
endfunction

// Little-endian byte memory
function automatic word_t load_model(input logic [2:0] f3, input logic [7:0] ba);
    logic [7:0]  b0;
    logic [15:0] h;
    word_t       r;
    b0 = mbyte[ba];
    h  = {mbyte[ba + 8'd1], b0};
    case (f3)
        3'b000:  r = {{24{b0[7]}}, b0};
        3'b001:  r = {{16{h[15]}}, h};
        3'b100:  r = {24'b0, b0};
        3'b101:  r = {16'b0, h};
        default: r = {mbyte[ba + 8'd3], mbyte[ba + 8'd2], h};
    endcase
    return r;
endfunction

function automatic logic reads_reg(
    input logic      use1,
    input logic      use2,
    input reg_addr_t rs1,
    input reg_addr_t rs2,
    input reg_addr_t r
);
    return (r != '0) && ((use1 && (rs1 == r)) || (use2 && (rs2 == r)));
endfunction

task automatic run_model();
    word_t     pc;
    word_t     insn;
    word_t     a;
    word_t     b;
    word_t     imm_i;
    word_t     addr;
    word_t     res;
    word_t     next_pc;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t prev_rd [2];
    logic      prev_load;
    logic      we;
    logic      use1;
    logic      use2;
    int        kind;
    int        steps;
    exp_t      e;
    for (steps = 0; steps < 32; steps++) begin
        mreg[steps] = '0;
    end
    pc         = `RV_RESET_PC;
    prev_rd[0] = '0;
    prev_rd[1] = '0;
    prev_load  = 1'b0;
    for (steps = 0; steps < 1000; steps++) begin
        insn    = prog[pc[9:2]];
        rd      = insn[11:7];
        rs1     = insn[19:15];
        rs2     = insn[24:20];
        a       = mreg[rs1];
        b       = mreg[rs2];
        imm_i   = {{20{insn[31]}}, insn[31:20]};
        res     = '0;
        we      = 1'b0;
        use1    = 1'b1;
        use2    = 1'b0;
        kind    = K_ARITH;
        next_pc = pc + 32'd4;
        case (insn[6:0])
            7'b0110011: begin
                we   = 1'b1;
                use2 = 1'b1;
                res  = alu_model(insn[14:12], insn[30], a, b);
            end
            7'b0010011: begin
                we  = 1'b1;
                // Bit 30 is an immediate bit except in SRAI
                res = alu_model(insn[14:12], insn[30] && (insn[14:12] == 3'b101), a, imm_i);
            end
            7'b0110111, 7'b0010111: begin
                we   = 1'b1;
                use1 = 1'b0;
                res  = {insn[31:12], 12'b0};
                if (insn[5:4] == 2'b01) begin
                    res = res + pc;
                end
            end
            7'b0000011: begin
                we   = 1'b1;
                kind = K_MEM;
                addr = a + imm_i;
                res  = load_model(insn[14:12], addr[7:0]);
            end
            7'b0100011: begin
                use2 = 1'b1;
                kind = K_MEM;
                addr = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
                mbyte[addr[7:0]] = b[7:0];
                if (insn[13:12] != 2'b00) begin
                    mbyte[addr[7:0] + 8'd1] = b[15:8];
                end
                if (insn[13:12] == 2'b10) begin
                    mbyte[addr[7:0] + 8'd2] = b[23:16];
                    mbyte[addr[7:0] + 8'd3] = b[31:24];
                end
            end
            7'b1100011: begin
                use2 = 1'b1;
                kind = K_CTRL;
                if (branch_taken(insn[14:12], a, b)) begin
                    next_pc = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25],
                                    insn[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                we      = 1'b1;
                use1    = 1'b0;
                kind    = K_CTRL;
                res     = pc + 32'd4;
                next_pc = pc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20],
                                insn[30:21], 1'b0};
            end
            default: begin
                use1 = 1'b0;
            end
        endcase
        if (prev_load && reads_reg(use1, use2, rs1, rs2, prev_rd[0])) begin
            kind = K_LOADUSE;
        end else if (reads_reg(use1, use2, rs1, rs2, prev_rd[0]) ||
                     reads_reg(use1, use2, rs1, rs2, prev_rd[1])) begin
            kind = K_DEP;
        end
        e.pc    = pc;
        e.rd_we = we && (rd != '0);
        e.rd    = rd;
        e.data  = res;
        e.kind  = 3'(kind);
        exp_q.push_back(e);
        if (e.rd_we) begin
            mreg[rd] = res;
        end
        prev_rd[1] = prev_rd[0];
        prev_rd[0] = e.rd_we ? rd : '0;
        prev_load  = (insn[6:0] == 7'b0000011);
        if (next_pc == pc) begin
            break;
        end
        pc = next_pc;
    end
endtask

`endif

// ==== tb_rv_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_defines.svh"

module tb_rv_pipe;
    import rv_pipe_pkg::*;

    localparam int          PROG_LEN   = 200;
    localparam int          IDLE_LIMIT = 40;
    localparam logic [31:0] LFSR_SEED  = 32'hbca6_c6eb;
    localparam word_t       NOP        = 32'h0000_0013;

    logic        clk;
    logic        rst_n;
    word_t       imem_data;
    word_t       imem_addr;
    logic        insn_vld;
    word_t       pc_debug;
    retire_t     retire;
    logic [31:0] lfsr_state;
    int          checks [6];
    int          errors [6];
    string       kind_name [6] = '{"reset", "arithmetic", "dependent operands",
                                   "load-use", "control flow", "memory"};

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

`include "rv_iss_model.svh"

    exp_t e;
    int   idle;
    logic first;
    logic timed_out;
    int   total_checks;
    int   total_errors;
    int   k;

    task automatic check_value(
        input string what,
        input word_t got,
        input word_t exp,
        input int    kind
    );
        checks[kind]++;
        if (got !== exp) begin
            errors[kind]++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    rv_pipe UUT (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .imem_data_i (imem_data),
        .imem_addr_o (imem_addr),
        .insn_vld_o  (insn_vld),
        .pc_debug_o  (pc_debug),
        .retire_o    (retire)
    );

    // Fetches past the self-loop see no-ops
    assign imem_data = (imem_addr < word_t'(4 * PROG_LEN)) ? prog[imem_addr[9:2]] : NOP;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n      = 1'b0;
        lfsr_state = LFSR_SEED;
        gen_program();
        run_model();
        repeat (4) begin
            @(negedge clk);
            check_value("insn_vld_o in reset", word_t'(insn_vld), '0, K_RESET);
            check_value("imem_addr_o in reset", imem_addr, `RV_RESET_PC, K_RESET);
        end
        rst_n     = 1'b1;
        first     = 1'b1;
        timed_out = 1'b0;
        idle      = IDLE_LIMIT;
        // Retire outputs are registered, so the falling edge sees each entry once
        while ((exp_q.size() > 0) && !timed_out) begin
            @(negedge clk);
            if ((insn_vld === 1'b1) || (retire.valid === 1'b1)) begin
                e = exp_q.pop_front();
                if (first) begin
                    check_value("first retired pc", pc_debug, `RV_RESET_PC, K_RESET);
                    first = 1'b0;
                end
                check_value("insn_vld_o", word_t'(insn_vld), word_t'(1'b1), int'(e.kind));
                check_value("retire_o.valid", word_t'(retire.valid), word_t'(1'b1),
                            int'(e.kind));
                check_value("retired pc", pc_debug, e.pc, int'(e.kind));
                check_value("retire_o.pc", retire.pc, e.pc, int'(e.kind));
                check_value("rd_we", word_t'(retire.rd_we), word_t'(e.rd_we), int'(e.kind));
                if (e.rd_we) begin
                    check_value("rd", word_t'(retire.rd), word_t'(e.rd), int'(e.kind));
                    check_value("rd_data", retire.rd_data, e.data, int'(e.kind));
                end
                idle = IDLE_LIMIT;
            end else begin
                idle = idle - 1;
                if (idle == 0) begin
                    timed_out = 1'b1;
                end
            end
        end
        if (timed_out) begin
            $display("Timeout at %0t ns: the pipeline stopped retiring with %0d entries left",
                     $time, exp_q.size());
            $display("Simulation failed");
            $finish;
        end else begin
            total_checks = 0;
            total_errors = 0;
            for (k = 0; k < 6; k++) begin
                $display("%s: %0d checks, %0d errors", kind_name[k], checks[k], errors[k]);
                total_checks = total_checks + checks[k];
                total_errors = total_errors + errors[k];
            end
            $display("Totals: %0d checks, %0d errors", total_checks, total_errors);
            if (total_errors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
